//--- list.f
+incdir+include
hw/isaPkg.sv
hw/pipePkg.sv
hw/forwardJudge.sv
hw/regFile.sv
hw/execUnit.sv
hw/simplePipe.sv
verif/simplePipeTb.sv

//--- Makefile
# Verilator build and run for the simplePipe testbench.
# Any variable can be overridden, for example: make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= simplePipeTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard hw/*.sv verif/*.sv include/*.svh)
EXE     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(EXE) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/tbModel.svh
`ifndef TBMODEL_SVH
`define TBMODEL_SVH

logic [15:0] modelRegs [8];

function automatic isaPkg::instFields mkArith(isaPkg::arithOp op, logic [2:0] ra,
                                              logic [2:0] rb, logic [3:0] sh);
   return '{op: isaPkg::opArith, ra: ra, rb: rb, minor: op, low: sh};
endfunction

function automatic isaPkg::instFields mkImm(isaPkg::immOp op, logic [2:0] rb, logic [7:0] d);
   return '{op: isaPkg::opImm, ra: op, rb: rb, minor: isaPkg::arithOp'(d[7:4]), low: d[3:0]};
endfunction

function automatic isaPkg::instFields mkMem(isaPkg::majorOp op, logic [2:0] ra,
                                            logic [2:0] rb, logic [7:0] d);
   return '{op: op, ra: ra, rb: rb, minor: isaPkg::arithOp'(d[7:4]), low: d[3:0]};
endfunction

// In-order model, applied when an instruction is issued.
function automatic void modelStep(input isaPkg::instFields f, output logic wr,
                                  output logic [2:0] dst, output logic [15:0] data);
   logic [15:0] a;
   logic [15:0] b;
   logic [15:0] sext;
   logic [3:0]  sh;
   a    = modelRegs[f.ra];
   b    = modelRegs[f.rb];
   sh   = f.low;
   sext = {{8{f.minor[3]}}, f.minor, f.low};
   wr   = 1'b1;
   data = '0;
   dst  = f.rb;
   if (f.op == isaPkg::opArith) begin
      case (f.minor)
         isaPkg::arAdd: data = b + a;
         isaPkg::arSub: data = b - a;
         isaPkg::arAnd: data = b & a;
         isaPkg::arOr:  data = b | a;
         isaPkg::arXor: data = b ^ a;
         isaPkg::arMov: data = a;
         isaPkg::arSll: data = b << sh;
         isaPkg::arSlr: data = (b << sh) | (b >> (16 - sh));
         isaPkg::arSrl: data = b >> sh;
         isaPkg::arSra: data = $signed(b) >>> sh;
         default:       wr = 1'b0;
      endcase
   end else if (f.op == isaPkg::opImm && f.ra == isaPkg::imLi) begin
      data = sext;
   end else if (f.op == isaPkg::opImm && f.ra == isaPkg::imAddi) begin
      data = b + sext;
   end else begin
      wr = 1'b0;
   end
   if (wr) begin
      modelRegs[f.rb] = data;
   end
endfunction

`endif

//--- verif/simplePipeTb.sv
`timescale 1ns/1ps

module simplePipeTb;

   localparam int drainLimit  = 40;
   localparam int flushCycles = 4; // Issue to the last write-back sample.

   typedef struct packed {
      logic [2:0]  dst;
      logic [15:0] data;
   } wbExp;

   logic              clk;
   logic              rstN;
   logic              instValid;
   isaPkg::instFields inst;
   logic              wbValid;
   logic [2:0]        wbReg;
   logic [15:0]       wbData;

   wbExp   expQ[$];
   wbExp   expHead;
   logic   expPending;
   integer seed;
   string  testName;
   int     testErrs;
   int     errCount;
   int     testCount;
   int     failedTests;
   int     checks;

   `include "tbModel.svh"

   simplePipe uut (
      .clk       (clk),
      .rstN      (rstN),
      .instValid (instValid),
      .inst      (inst),
      .wbValid   (wbValid),
      .wbReg     (wbReg),
      .wbData    (wbData)
   );

   always #4 clk = ~clk;

   // Queue front for the coming edge.
   always @(negedge clk) begin
      expPending = expQ.size() > 0;
      if (expPending) begin
         expHead = expQ[0];
      end
   end

   always @(posedge clk) begin
      if (rstN && wbValid) begin
         checks++;
         if (expQ.size() > 0) begin
            void'(expQ.pop_front());
         end
      end
   end

   wbExpected: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> expPending)
      else begin
         errCount++;
         testErrs++;
         $display("Unexpected write-back to r%0d in %s while nothing was pending",
                  $sampled(wbReg), testName);
      end

   wbMatches: assert property (@(posedge clk) disable iff (!rstN)
      wbValid && expPending |-> wbReg == expHead.dst && wbData == expHead.data)
      else begin
         errCount++;
         testErrs++;
         $display("Fail %s expected r%0d=%h actual r%0d=%h", testName,
                  $sampled(expHead.dst), $sampled(expHead.data),
                  $sampled(wbReg), $sampled(wbData));
      end

   task automatic startTest(input string name);
      testName = name;
      testErrs = 0;
      testCount++;
   endtask

   // Model runs at issue time, so expected values are in program order.
   task automatic issue(input isaPkg::instFields f);
      logic        wr;
      logic [2:0]  dst;
      logic [15:0] data;
      wbExp        e;
      modelStep(f, wr, dst, data);
      if (wr) begin
         e.dst  = dst;
         e.data = data;
         expQ.push_back(e);
      end
      instValid <= 1'b1;
      inst      <= f;
      @(posedge clk);
   endtask

   task automatic idle(input int n);
      instValid <= 1'b0;
      repeat (n) @(posedge clk);
   endtask

   task automatic endTest();
      int waited;
      instValid <= 1'b0;
      waited = 0;
      while ((expQ.size() != 0 || waited < flushCycles) && waited < drainLimit) begin
         @(posedge clk);
         waited++;
      end
      if (expQ.size() != 0) begin
         $display("Timeout in %s: %0d write-backs never arrived", testName, expQ.size());
         expQ.delete();
         failedTests++;
      end else begin
         repeat (3) @(posedge clk); // Let the last checks settle.
         if (testErrs == 0) begin
            $display("ok      %s", testName);
         end else begin
            $display("errors  %s: %0d", testName, testErrs);
            failedTests++;
         end
      end
   endtask

   task automatic runRandom(input int count);
      logic [31:0]       r;
      logic [3:0]        minor;
      isaPkg::instFields f;
      for (int i = 0; i < count; i++) begin
         r     = $random(seed);
         minor = r[7:4];
         if (minor == 4'd7 || minor == 4'd15) begin
            minor = 4'd6; // Unused codes become MOV.
         end
         case (r[10:8])
            3'd5:    f = mkImm(isaPkg::imLi, r[13:11], r[23:16]);
            3'd6:    f = mkImm(isaPkg::imAddi, r[13:11], r[23:16]);
            3'd7:    f = mkMem(isaPkg::majorOp'(r[24] ? isaPkg::opStore : isaPkg::opLoad),
                               r[16:14], r[13:11], r[23:16]);
            default: f = mkArith(isaPkg::arithOp'(minor), r[16:14], r[13:11], r[3:0]);
         endcase
         if (r[31:29] == 3'd0) begin
            idle(1);
         end
         issue(f);
      end
   endtask

   initial begin
      clk         = 1'b0;
      rstN        = 1'b0;
      instValid   = 1'b0;
      inst        = '0;
      seed        = 6;
      expPending  = 1'b0;
      errCount    = 0;
      testCount   = 0;
      failedTests = 0;
      checks      = 0;
      for (int i = 0; i < 8; i++) begin
         modelRegs[i] = '0;
      end
      repeat (8) @(posedge clk);
      rstN <= 1'b1;

      startTest("resetState");
      idle(4);
      issue(mkArith(isaPkg::arMov, 3'd3, 3'd5, 4'd0));
      issue(mkArith(isaPkg::arMov, 3'd7, 3'd0, 4'd0));
      endTest();

      startTest("noForward");
      issue(mkImm(isaPkg::imLi, 3'd1, 8'h25));
      issue(mkImm(isaPkg::imLi, 3'd2, 8'hFD));
      idle(3);
      issue(mkArith(isaPkg::arAdd, 3'd1, 3'd2, 4'd0));
      endTest();

      startTest("oneBefore");
      issue(mkImm(isaPkg::imLi, 3'd3, 8'h40));
      issue(mkArith(isaPkg::arAdd, 3'd3, 3'd4, 4'd0)); // Operand A.
      issue(mkImm(isaPkg::imLi, 3'd6, 8'h11));
      issue(mkArith(isaPkg::arSub, 3'd1, 3'd6, 4'd0)); // Operand B.
      endTest();

      startTest("twoBefore");
      issue(mkImm(isaPkg::imLi, 3'd4, 8'h7F));
      issue(mkImm(isaPkg::imLi, 3'd7, 8'h81));
      issue(mkArith(isaPkg::arXor, 3'd4, 3'd1, 4'd0));
      issue(mkImm(isaPkg::imLi, 3'd2, 8'h0C));
      issue(mkArith(isaPkg::arMov, 3'd0, 3'd6, 4'd0));
      issue(mkArith(isaPkg::arSll, 3'd0, 3'd2, 4'd3));
      issue(mkImm(isaPkg::imLi, 3'd5, 8'h33));
      issue(mkImm(isaPkg::imLi, 3'd6, 8'h01));
      issue(mkImm(isaPkg::imLi, 3'd7, 8'h02));
      issue(mkArith(isaPkg::arOr, 3'd5, 3'd0, 4'd0)); // Producer sits in write-back.
      endTest();

      startTest("newestWins");
      issue(mkImm(isaPkg::imLi, 3'd1, 8'h10));
      issue(mkImm(isaPkg::imLi, 3'd1, 8'h20));
      issue(mkArith(isaPkg::arAdd, 3'd1, 3'd3, 4'd0));
      issue(mkImm(isaPkg::imAddi, 3'd1, 8'h05));
      issue(mkArith(isaPkg::arCmp, 3'd1, 3'd1, 4'd0));
      issue(mkMem(isaPkg::opStore, 3'd1, 3'd1, 8'h00));
      issue(mkArith(isaPkg::arMov, 3'd1, 3'd2, 4'd0));
      endTest();

      startTest("random");
      runRandom(200);
      endTest();

      $display("Tests %0d, with errors %0d, write-backs checked %0d, mismatches %0d",
               testCount, failedTests, checks, errCount);
      if (errCount == 0 && failedTests == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- hw/simplePipe.sv
`timescale 1ns/1ps

module simplePipe (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          instValid,
   input  isaPkg::instFields             inst,
   output logic                          wbValid,
   output logic [pipePkg::addrWidth-1:0] wbReg,
   output logic [pipePkg::dataWidth-1:0] wbData
);

   logic [pipePkg::dataWidth-1:0] fileA;
   logic [pipePkg::dataWidth-1:0] fileB;
   pipePkg::fwdSel                selA;
   pipePkg::fwdSel                selB;
   isaPkg::instFields             exInst;
   logic                          exValid;
   pipePkg::stageRec              holdRec;
   pipePkg::stageRec              wbRec;

   regFile uRegFile (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddrA (inst.ra),
      .rdAddrB (inst.rb),
      .rdDataA (fileA),
      .rdDataB (fileB),
      .wrEn    (wbValid),
      .wrAddr  (wbReg),
      .wrData  (wbData)
   );

   forwardJudge uJudge (
      .consumer      (exInst),
      .consumerValid (exValid),
      .oneBefore     (holdRec),
      .twoBefore     (wbRec),
      .selA          (selA),
      .selB          (selB)
   );

   execUnit uExec (
      .clk       (clk),
      .rstN      (rstN),
      .instValid (instValid),
      .inst      (inst),
      .fileA     (fileA),
      .fileB     (fileB),
      .selA      (selA),
      .selB      (selB),
      .exInst    (exInst),
      .exValid   (exValid),
      .holdRec   (holdRec),
      .wbRec     (wbRec)
   );

   assign wbValid = wbRec.valid && wbRec.wr;
   assign wbReg   = wbRec.dst;
   assign wbData  = wbRec.result;

   // A forwarded operand must come from a stage that really writes.
   fwdFromWriter: assert property (@(posedge clk) disable iff (!rstN)
      ((selA == pipePkg::fromOne || selB == pipePkg::fromOne) |-> holdRec.valid && holdRec.wr)
      and ((selA == pipePkg::fromTwo || selB == pipePkg::fromTwo) |-> wbRec.valid && wbRec.wr));

endmodule

//--- hw/execUnit.sv
`timescale 1ns/1ps

module execUnit (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          instValid,
   input  isaPkg::instFields             inst,
   input  logic [pipePkg::dataWidth-1:0] fileA,
   input  logic [pipePkg::dataWidth-1:0] fileB,
   input  pipePkg::fwdSel                selA,
   input  pipePkg::fwdSel                selB,
   output isaPkg::instFields             exInst,
   output logic                          exValid,
   output pipePkg::stageRec              holdRec,
   output pipePkg::stageRec              wbRec
);

   logic [pipePkg::dataWidth-1:0] exFileA;
   logic [pipePkg::dataWidth-1:0] exFileB;
   logic [pipePkg::dataWidth-1:0] lateA;
   logic [pipePkg::dataWidth-1:0] lateB;
   logic [pipePkg::dataWidth-1:0] opA;
   logic [pipePkg::dataWidth-1:0] opB;
   logic [7:0]                    immVal;
   logic [pipePkg::dataWidth-1:0] sext;
   logic [pipePkg::dataWidth-1:0] result;
   logic [3:0]                    sh;
   logic                          computes;
   logic                          wbWrites;
   pipePkg::stageRec              exRec;

   function automatic logic [pipePkg::dataWidth-1:0] pickOp(
      pipePkg::fwdSel sel, logic [pipePkg::dataWidth-1:0] fromFile);
      logic [pipePkg::dataWidth-1:0] val;
      case (sel)
         pipePkg::fromOne: val = holdRec.result;
         pipePkg::fromTwo: val = wbRec.result;
         default:          val = fromFile;
      endcase
      return val;
   endfunction

   // File is written one edge after write-back, so catch that value at capture.
   assign wbWrites = wbRec.valid && wbRec.wr;
   assign lateA = (wbWrites && wbRec.dst == inst.ra) ? wbRec.result : fileA;
   assign lateB = (wbWrites && wbRec.dst == inst.rb) ? wbRec.result : fileB;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         exValid <= 1'b0;
      end else begin
         exValid <= instValid; // Bubble when idle.
      end
   end

   always_ff @(posedge clk) begin
      exInst  <= inst;
      exFileA <= lateA;
      exFileB <= lateB;
   end

   always_comb begin
      opA = pickOp(selA, exFileA);
      opB = pickOp(selB, exFileB);
   end

   assign sh     = exInst.low;
   assign immVal = isaPkg::immD(exInst);
   assign sext   = {{8{immVal[7]}}, immVal};

   always_comb begin
      result   = '0;
      computes = 1'b0;
      if (exInst.op == isaPkg::opArith) begin
         computes = 1'b1;
         case (exInst.minor)
            isaPkg::arAdd: result = opB + opA;
            isaPkg::arSub: result = opB - opA;
            isaPkg::arAnd: result = opB & opA;
            isaPkg::arOr:  result = opB | opA;
            isaPkg::arXor: result = opB ^ opA;
            isaPkg::arMov: result = opA;
            isaPkg::arSll: result = opB << sh;
            isaPkg::arSlr: result = (opB << sh) | (opB >> (pipePkg::dataWidth - sh));
            isaPkg::arSrl: result = opB >> sh;
            isaPkg::arSra: result = $signed(opB) >>> sh;
            default:       computes = 1'b0; // CMP, IN, OUT, HLT.
         endcase
      end else if (exInst.op == isaPkg::opImm) begin
         computes = 1'b1;
         case (exInst.ra)
            isaPkg::imLi:   result = sext;
            isaPkg::imAddi: result = opB + sext;
            default:        computes = 1'b0; // Branches.
         endcase
      end
   end

   assign exRec = '{valid:  exValid,
                    inst:   exInst,
                    wr:     exValid && computes && isaPkg::isProducer(exInst),
                    dst:    exInst.rb,
                    result: result};

   always_ff @(posedge clk) begin
      if (!rstN) begin
         holdRec.valid <= 1'b0;
         holdRec.wr    <= 1'b0;
         wbRec.valid   <= 1'b0;
         wbRec.wr      <= 1'b0;
      end else begin
         holdRec <= exRec;
         wbRec   <= holdRec;
      end
   end

   wbWrOnlyValid: assert property (@(posedge clk) disable iff (!rstN)
      wbRec.wr |-> wbRec.valid);

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic [pipePkg::addrWidth-1:0]       rdAddrA,
   input  logic [pipePkg::addrWidth-1:0]       rdAddrB,
   output logic [pipePkg::dataWidth-1:0]       rdDataA,
   output logic [pipePkg::dataWidth-1:0]       rdDataB,
   input  logic                                wrEn,
   input  logic [pipePkg::addrWidth-1:0]       wrAddr,
   input  logic [pipePkg::dataWidth-1:0]       wrData
);

   logic [pipePkg::dataWidth-1:0] regs [pipePkg::regCount];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < pipePkg::regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // No write-through here.
   assign rdDataA = regs[rdAddrA];
   assign rdDataB = regs[rdAddrB];

   wrAddrKnown: assert property (@(posedge clk) disable iff (!rstN)
      wrEn |-> !$isunknown(wrAddr));

endmodule

//--- hw/forwardJudge.sv
`timescale 1ns/1ps

module forwardJudge (
   input  isaPkg::instFields consumer,
   input  logic              consumerValid,
   input  pipePkg::stageRec  oneBefore,
   input  pipePkg::stageRec  twoBefore,
   output pipePkg::fwdSel    selA,
   output pipePkg::fwdSel    selB
);

   logic oneWrites;
   logic twoWrites;
   logic oneA;
   logic twoA;
   logic oneB;
   logic twoB;

   // Newer result wins.
   function automatic pipePkg::fwdSel pick(logic one, logic two);
      pipePkg::fwdSel sel;
      sel = pipePkg::fromFile;
      if (one) begin
         sel = pipePkg::fromOne;
      end else if (two) begin
         sel = pipePkg::fromTwo;
      end
      return sel;
   endfunction

   // The write flag drops IN, which the rule still counts as a producer.
   assign oneWrites = oneBefore.valid && isaPkg::isProducer(oneBefore.inst) && oneBefore.wr;
   assign twoWrites = twoBefore.valid && isaPkg::isProducer(twoBefore.inst) && twoBefore.wr;

   assign oneA = consumerValid && oneWrites && isaPkg::readsRa(consumer)
                 && consumer.ra == oneBefore.inst.rb;
   assign twoA = consumerValid && twoWrites && isaPkg::readsRa(consumer)
                 && consumer.ra == twoBefore.inst.rb;
   assign oneB = consumerValid && oneWrites && isaPkg::readsRb(consumer)
                 && consumer.rb == oneBefore.inst.rb;
   assign twoB = consumerValid && twoWrites && isaPkg::readsRb(consumer)
                 && consumer.rb == twoBefore.inst.rb;

   always_comb begin
      selA = pick(oneA, twoA);
      selB = pick(oneB, twoB);
   end

endmodule

//--- hw/pipePkg.sv
package pipePkg;

   localparam int dataWidth = 16;
   localparam int regCount  = 8;
   localparam int addrWidth = $clog2(regCount);

   // Operand source picked by the judgment.
   typedef enum logic [1:0] {
      fromFile = 2'd0,
      fromOne  = 2'd1,
      fromTwo  = 2'd2
   } fwdSel;

   // Hold and write-back stage record.
   typedef struct packed {
      logic                 valid;
      isaPkg::instFields    inst;
      logic                 wr;     // Result goes to the file.
      logic [addrWidth-1:0] dst;
      logic [dataWidth-1:0] result;
   } stageRec;

endpackage

//--- hw/isaPkg.sv
package isaPkg;

   typedef enum logic [1:0] {
      opLoad  = 2'd0,
      opStore = 2'd1,
      opImm   = 2'd2,
      opArith = 2'd3
   } majorOp;

   typedef enum logic [3:0] {
      arAdd = 4'd0,
      arSub = 4'd1,
      arAnd = 4'd2,
      arOr  = 4'd3,
      arXor = 4'd4,
      arCmp = 4'd5,
      arMov = 4'd6,
      arSll = 4'd8,
      arSlr = 4'd9,
      arSrl = 4'd10,
      arSra = 4'd11,
      arIn  = 4'd12,
      arOut = 4'd13,
      arHlt = 4'd14
   } arithOp;

   // Ra field under opImm.
   typedef enum logic [2:0] {
      imLi   = 3'd0,
      imAddi = 3'd1,
      imB    = 3'd2,
      imBe   = 3'd3,
      imBlt  = 3'd4,
      imBle  = 3'd5,
      imBr   = 3'd6,
      imBne  = 3'd7
   } immOp;

   typedef struct packed {
      majorOp     op;    // Bits 15:14.
      logic [2:0] ra;    // Bits 13:11.
      logic [2:0] rb;    // Bits 10:8.
      arithOp     minor; // Bits 7:4, upper half of d.
      logic [3:0] low;   // Shift amount, lower half of d.
   } instFields;

   function automatic logic [7:0] immD(instFields f);
      return {f.minor, f.low};
   endfunction

   // Writes Rb. IN is in this set but computes nothing here.
   function automatic logic isProducer(instFields f);
      logic arithWr;
      logic immWr;
      arithWr = f.op == opArith && f.minor <= arIn && f.minor != arCmp && f.minor != 4'd7;
      immWr   = f.op == opImm && (f.ra == imLi || f.ra == imAddi);
      return arithWr || immWr;
   endfunction

   function automatic logic readsRa(instFields f);
      return (f.op == opArith && (f.minor <= arMov || f.minor == arOut)) || f.op == opStore;
   endfunction

   function automatic logic readsRb(instFields f);
      logic arithRd;
      logic immRd;
      arithRd = f.op == opArith && (f.minor <= arCmp || (f.minor >= arSll && f.minor <= arSra));
      immRd   = f.op == opImm && (f.ra == imAddi || f.ra == imB || f.ra == imBr);
      return arithRd || immRd || f.op == opStore || f.op == opLoad;
   endfunction

endpackage
